// File: axi_read_splitter.f
src/burst_split_pkg.sv
src/len_slot.sv
src/ar_splitter.sv
src/r_last_tracker.sv
src/axi_read_splitter.sv
test/tb_axi_read_splitter.sv

// File: build.sh
#!/bin/sh
# Compile the testbench with Verilator and run it, result taken from the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Cannot create $BUILD_DIR"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --top-module tb_axi_read_splitter \
  -Mdir "$BUILD_DIR/obj" \
  -f axi_read_splitter.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"$BUILD_DIR/obj/Vtb_axi_read_splitter" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
exit 0

// File: src/ar_splitter.sv
`timescale 1ns/1ps

module ar_splitter import burst_split_pkg::*; #(
  parameter int unsigned MAX_TXNS = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Upstream AR
  input  ar_chan_t            ar_i,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  // Downstream AR
  output ar_chan_t            ar_o,
  output logic                ar_valid_o,
  input  logic                ar_ready_i,
  // Length slot ring
  input  logic [MAX_TXNS-1:0] slot_busy_i,
  output logic [MAX_TXNS-1:0] slot_load_o,
  output len_t                slot_len_o
);

  localparam int unsigned PTR_W = (MAX_TXNS > 1) ? $clog2(MAX_TXNS) : 1;

  typedef enum logic {
    IDLE,
    BUSY
  } state_t;

  state_t           state_q, state_d;
  ar_chan_t         ar_q, ar_d;
  logic [PTR_W-1:0] wr_ptr_q;
  logic             alloc;
  logic             wr_slot_free;

  // Address of the following beat, FIXED bursts stay on the base
  function automatic logic [ADDR_W-1:0] next_addr(ar_chan_t ar);
    if (ar.burst == BURST_INCR) begin
      return ar.addr + (ADDR_W'(1) << ar.size);
    end
    return ar.addr;
  endfunction

  assign wr_slot_free = ~slot_busy_i[wr_ptr_q];

  // --------------------------------------------------
  // Split FSM
  // --------------------------------------------------
  always_comb begin
    state_d    = state_q;
    ar_d       = ar_q;
    ar_o       = ar_q;
    ar_o.len   = '0;
    ar_valid_o = 1'b0;
    ar_ready_o = 1'b0;
    alloc      = 1'b0;
    case (state_q)
      IDLE: begin
        ar_o     = ar_i;
        ar_o.len = '0;
        if (ar_valid_i && wr_slot_free) begin
          ar_valid_o = 1'b1;
          if (ar_i.len == '0) begin
            // Single beat goes straight through
            ar_ready_o = ar_ready_i;
            alloc      = ar_ready_i;
          end else begin
            // Take the burst now and keep it for the remaining beats
            ar_ready_o = 1'b1;
            alloc      = 1'b1;
            ar_d       = ar_i;
            state_d    = BUSY;
            if (ar_ready_i) begin
              ar_d.len  = ar_i.len - len_t'(1);
              ar_d.addr = next_addr(ar_i);
            end
          end
        end
      end
      BUSY: begin
        ar_valid_o = 1'b1;
        if (ar_ready_i) begin
          if (ar_q.len == '0) begin
            state_d = IDLE;
          end else begin
            ar_d.len  = ar_q.len - len_t'(1);
            ar_d.addr = next_addr(ar_q);
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Load the slot under the write pointer
  always_comb begin
    slot_load_o           = '0;
    slot_load_o[wr_ptr_q] = alloc;
  end
  assign slot_len_o = ar_i.len;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= IDLE;
      wr_ptr_q <= '0;
    end else begin
      state_q <= state_d;
      if (alloc) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_TXNS - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
    end
  end

  // Held burst with beats left and next address
  always_ff @(posedge clk_i) begin
    ar_q <= ar_d;
  end

  // A pending downstream request holds its payload until taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("ar_splitter: downstream request changed before acceptance");

  // Upstream keeps WRAP bursts to a single beat
  assert property (@(posedge clk_i) disable iff (reset_i)
    (ar_valid_i && ar_i.burst == BURST_WRAP) |-> ar_i.len == '0)
    else $error("ar_splitter: WRAP burst longer than one beat offered");

endmodule

// File: src/axi_read_splitter.sv
`timescale 1ns/1ps

module axi_read_splitter import burst_split_pkg::*; #(
  parameter int unsigned MAX_TXNS = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,
  // Upstream
  input  ar_chan_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  output r_chan_t  r_o,
  output logic     r_valid_o,
  input  logic     r_ready_i,
  // Downstream
  output ar_chan_t ar_o,
  output logic     ar_valid_o,
  input  logic     ar_ready_i,
  input  r_chan_t  r_i,
  input  logic     r_valid_i,
  output logic     r_ready_o
);

  logic [MAX_TXNS-1:0] slot_load;
  logic [MAX_TXNS-1:0] slot_busy;
  logic [MAX_TXNS-1:0] slot_dec;
  len_t                slot_len;
  len_t [MAX_TXNS-1:0] slot_remain;

  ar_splitter #(
    .MAX_TXNS (MAX_TXNS)
  ) i_ar_splitter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ar_i        (ar_i),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .ar_o        (ar_o),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .slot_busy_i (slot_busy),
    .slot_load_o (slot_load),
    .slot_len_o  (slot_len)
  );

  // --------------------------------------------------
  // Ring of outstanding bursts
  // --------------------------------------------------
  for (genvar i = 0; i < MAX_TXNS; i++) begin : gen_slot
    len_slot i_len_slot (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .load_i   (slot_load[i]),
      .len_i    (slot_len),
      .dec_i    (slot_dec[i]),
      .busy_o   (slot_busy[i]),
      .remain_o (slot_remain[i])
    );
  end

  r_last_tracker #(
    .MAX_TXNS (MAX_TXNS)
  ) i_r_last_tracker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .r_i           (r_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .r_o           (r_o),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .slot_busy_i   (slot_busy),
    .slot_remain_i (slot_remain),
    .slot_dec_o    (slot_dec)
  );

endmodule

// File: src/burst_split_pkg.sv
package burst_split_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 4;

  // Burst length minus one, as carried on AR
  typedef logic [7:0] len_t;
  // log2 of bytes per beat
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;

  // AXI4 burst type codes
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;
  localparam burst_t BURST_WRAP  = 2'b10;

  // --------------------------------------------------
  // Channel payloads
  // --------------------------------------------------
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    len_t              len;
    size_t             size;
    burst_t            burst;
  } ar_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    resp_t             resp;
    logic              last;
  } r_chan_t;

endpackage

// File: src/len_slot.sv
`timescale 1ns/1ps

module len_slot import burst_split_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  // Written by the AR splitter
  input  logic load_i,
  input  len_t len_i,
  // Drained by the R tracker
  input  logic dec_i,
  output logic busy_o,
  output len_t remain_o
);

  // Beats still expected, up to 256
  logic [8:0] cnt_q;
  logic [8:0] remain;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= {1'b0, len_i} + 9'd1;
    end else if (dec_i) begin
      cnt_q <= cnt_q - 9'd1;
    end
  end

  assign busy_o = (cnt_q != '0);

  // Zero on the last beat of the burst
  assign remain   = cnt_q - 9'd1;
  assign remain_o = remain[7:0];

  // --------------------------------------------------
  // Ring discipline
  // --------------------------------------------------
  // R beats only arrive for bursts that were issued
  assert property (@(posedge clk_i) disable iff (reset_i)
    dec_i |-> busy_o)
    else $error("len_slot: decrement of a free slot");

  // Writer never overtakes the reader
  assert property (@(posedge clk_i) disable iff (reset_i)
    load_i |-> !busy_o)
    else $error("len_slot: load of a busy slot");

endmodule

// File: src/r_last_tracker.sv
`timescale 1ns/1ps

module r_last_tracker import burst_split_pkg::*; #(
  parameter int unsigned MAX_TXNS = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Downstream R
  input  r_chan_t             r_i,
  input  logic                r_valid_i,
  output logic                r_ready_o,
  // Upstream R
  output r_chan_t             r_o,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  // Length slot ring
  input  logic [MAX_TXNS-1:0] slot_busy_i,
  input  len_t [MAX_TXNS-1:0] slot_remain_i,
  output logic [MAX_TXNS-1:0] slot_dec_o
);

  localparam int unsigned PTR_W = (MAX_TXNS > 1) ? $clog2(MAX_TXNS) : 1;

  // Points at the oldest outstanding burst
  logic [PTR_W-1:0] rd_ptr_q;
  logic             head_busy;
  len_t             head_remain;
  logic             head_last;
  logic             beat_done;

  assign head_busy   = slot_busy_i[rd_ptr_q];
  assign head_remain = slot_remain_i[rd_ptr_q];
  assign head_last   = (head_remain == '0);

  // --------------------------------------------------
  // R channel
  // --------------------------------------------------
  // Payload passes through, last comes from the head slot
  always_comb begin
    r_o      = r_i;
    r_o.last = head_last;
  end

  assign r_valid_o = r_valid_i & head_busy;
  assign r_ready_o = r_ready_i & head_busy;

  // Beat counted only once upstream has taken it
  assign beat_done = r_valid_o & r_ready_i;

  // --------------------------------------------------
  // Slot drain
  // --------------------------------------------------
  always_comb begin
    slot_dec_o           = '0;
    slot_dec_o[rd_ptr_q] = beat_done;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
    end else if (beat_done && head_last) begin
      // Burst complete, move on to the next slot
      rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_TXNS - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
    end
  end

  // Downstream returns beats only for issued requests and in order
  assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_i |-> head_busy)
    else $error("r_last_tracker: R beat with no outstanding burst");

endmodule

// File: test/tb_axi_read_splitter.sv
`timescale 1ns/1ps

module tb_axi_read_splitter import burst_split_pkg::*; ();

  localparam int unsigned MAX_TXNS = 4;
  localparam int unsigned TIMEOUT  = 2000;
  localparam int unsigned N_RANDOM = 40;

  logic     clk_i      = 1'b0;
  logic     reset_i    = 1'b1;
  ar_chan_t ar_i       = '0;
  logic     ar_valid_i = 1'b0;
  logic     ar_ready_i = 1'b0;
  r_chan_t  r_i        = '0;
  logic     r_valid_i  = 1'b0;
  logic     r_ready_i  = 1'b0;
  logic     ar_ready_o;
  r_chan_t  r_o;
  logic     r_valid_o;
  ar_chan_t ar_o;
  logic     ar_valid_o;
  logic     r_ready_o;

  // Stimulus control
  logic        hold_r     = 1'b0;
  logic        full_check = 1'b0;
  // Expected traffic and the downstream model's pending requests
  ar_chan_t    exp_req_q[$];
  r_chan_t     exp_r_q[$];
  ar_chan_t    pend_q[$];
  int unsigned exp_beats   = 0;
  int unsigned ds_count    = 0;
  int unsigned us_count    = 0;
  int unsigned ds_errors   = 0;
  int unsigned us_errors   = 0;
  int unsigned prop_errors = 0;
  int unsigned flow_errors = 0;

  axi_read_splitter #(
    .MAX_TXNS (MAX_TXNS)
  ) dut0 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ar_i       (ar_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .r_o        (r_o),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .ar_o       (ar_o),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .r_i        (r_i),
    .r_valid_i  (r_valid_i),
    .r_ready_o  (r_ready_o)
  );

  initial begin
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v, inout int unsigned errs);
    assert (act_v == exp_v) else begin
      errs++;
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
    end
  endtask

  function automatic ar_chan_t make_burst(logic [ID_W-1:0] id, logic [ADDR_W-1:0] addr,
                                          len_t len, size_t size, burst_t burst);
    ar_chan_t ar;
    ar.id    = id;
    ar.addr  = addr;
    ar.len   = len;
    ar.size  = size;
    ar.burst = burst;
    return ar;
  endfunction

  // Lengths 0 to 7, sizes up to 4 bytes, addresses aligned to the size
  function automatic ar_chan_t random_burst();
    ar_chan_t ar;
    ar.id    = ID_W'($urandom_range(15));
    ar.len   = len_t'($urandom_range(7));
    ar.size  = size_t'($urandom_range(2));
    ar.burst = ($urandom_range(1) == 0) ? BURST_FIXED : BURST_INCR;
    ar.addr  = $urandom() & ~((ADDR_W'(1) << ar.size) - ADDR_W'(1));
    return ar;
  endfunction

  // --------------------------------------------------
  // Expected single-beat requests and R beats
  // --------------------------------------------------
  function automatic void expect_burst(ar_chan_t ar);
    ar_chan_t req;
    r_chan_t  beat;
    int       k;
    for (k = 0; k <= int'(ar.len); k++) begin
      req     = ar;
      req.len = '0;
      if (ar.burst == BURST_INCR) begin
        req.addr = ar.addr + (ADDR_W'(k) << ar.size);
      end
      exp_req_q.push_back(req);
      beat.id   = ar.id;
      beat.data = req.addr ^ 32'h5a5a5a5a;
      beat.resp = req.addr[1:0];
      beat.last = (k == int'(ar.len));
      exp_r_q.push_back(beat);
    end
    exp_beats += 32'(ar.len) + 1;
  endfunction

  // Downstream memory answers in request order
  function automatic r_chan_t answer(ar_chan_t req);
    r_chan_t beat;
    beat.id   = req.id;
    beat.data = req.addr ^ 32'h5a5a5a5a;
    beat.resp = req.addr[1:0];
    beat.last = 1'b1;
    return beat;
  endfunction

  always @(posedge clk_i) begin
    ar_ready_i <= ($urandom_range(9) < 7);
    r_ready_i  <= hold_r ? 1'b0 : ($urandom_range(9) < 7);
  end

  always @(posedge clk_i) begin : bus_model
    ar_chan_t req;
    r_chan_t  beat;
    if (reset_i) begin
      r_valid_i <= 1'b0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        expect_burst(ar_i);
      end
      if (ar_valid_o && ar_ready_i) begin
        ds_count++;
        if (exp_req_q.size() == 0) begin
          ds_errors++;
          $display("Downstream request at %0t with no burst outstanding", $time);
        end else begin
          req = exp_req_q.pop_front();
          check_value("ar_o.addr", 64'(req.addr), 64'(ar_o.addr), ds_errors);
          check_value("ar_o.id", 64'(req.id), 64'(ar_o.id), ds_errors);
          check_value("ar_o.len", 64'(req.len), 64'(ar_o.len), ds_errors);
          check_value("ar_o.size", 64'(req.size), 64'(ar_o.size), ds_errors);
          check_value("ar_o.burst", 64'(req.burst), 64'(ar_o.burst), ds_errors);
        end
        pend_q.push_back(ar_o);
      end
      if (r_valid_i && r_ready_o) begin
        pend_q.delete(0);
      end
      if (r_valid_o && r_ready_i) begin
        us_count++;
        if (exp_r_q.size() == 0) begin
          us_errors++;
          $display("Upstream R beat at %0t with no beat expected", $time);
        end else begin
          beat = exp_r_q.pop_front();
          check_value("r_o.id", 64'(beat.id), 64'(r_o.id), us_errors);
          check_value("r_o.data", 64'(beat.data), 64'(r_o.data), us_errors);
          check_value("r_o.resp", 64'(beat.resp), 64'(r_o.resp), us_errors);
          check_value("r_o.last", 64'(beat.last), 64'(r_o.last), us_errors);
        end
      end
      if (pend_q.size() > 0) begin
        r_valid_i <= 1'b1;
        r_i       <= answer(pend_q[0]);
      end else begin
        r_valid_i <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Handshake rules
  // --------------------------------------------------
  assert property (@(posedge clk_i) disable iff (reset_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else begin
      prop_errors++;
      $display("Downstream AR request changed or dropped before acceptance at %0t", $time);
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else begin
      prop_errors++;
      $display("Upstream R beat changed or dropped before acceptance at %0t", $time);
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    full_check && ar_valid_i |-> !ar_ready_o)
    else begin
      prop_errors++;
      $display("Burst accepted at %0t while every length slot was busy", $time);
    end

  task automatic wait_accept();
    int unsigned cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (!ar_ready_o && cycles < TIMEOUT);
    if (!ar_ready_o) begin
      flow_errors++;
      $display("Timeout: upstream burst not accepted within %0d cycles", TIMEOUT);
    end
    ar_valid_i <= 1'b0;
  endtask

  task automatic issue_burst(input ar_chan_t ar);
    @(posedge clk_i);
    ar_i       <= ar;
    ar_valid_i <= 1'b1;
    wait_accept();
  endtask

  task automatic wait_drain();
    int unsigned cycles;
    cycles = 0;
    while ((exp_r_q.size() != 0 || exp_req_q.size() != 0) && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (exp_r_q.size() != 0 || exp_req_q.size() != 0) begin
      flow_errors++;
      $display("Timeout: outstanding bursts did not complete within %0d cycles", TIMEOUT);
    end
  endtask

  initial begin
    int unsigned i;
    void'($urandom(32'h3701eac1));
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_value("ar_valid_o", 64'(0), 64'(ar_valid_o), flow_errors);
    check_value("r_valid_o", 64'(0), 64'(r_valid_o), flow_errors);
    check_value("r_ready_o", 64'(0), 64'(r_ready_o), flow_errors);

    // Directed INCR, FIXED and single-beat bursts
    issue_burst(make_burst(4'h3, 32'h0000_1000, 8'd7, 3'd2, BURST_INCR));
    issue_burst(make_burst(4'h9, 32'h0000_2042, 8'd5, 3'd1, BURST_FIXED));
    issue_burst(make_burst(4'h5, 32'h0000_3004, 8'd0, 3'd2, BURST_INCR));
    wait_drain();

    for (i = 0; i < N_RANDOM; i++) begin
      issue_burst(random_burst());
    end
    wait_drain();

    // No R beat drains, so every slot fills up
    hold_r <= 1'b1;
    repeat (2) @(posedge clk_i);
    for (i = 0; i < MAX_TXNS; i++) begin
      issue_burst(random_burst());
    end
    @(posedge clk_i);
    ar_i       <= random_burst();
    ar_valid_i <= 1'b1;
    full_check <= 1'b1;
    repeat (40) @(posedge clk_i);
    full_check <= 1'b0;
    hold_r     <= 1'b0;
    wait_accept();
    issue_burst(random_burst());
    wait_drain();

    repeat (5) @(posedge clk_i);
    check_value("downstream request count", 64'(exp_beats), 64'(ds_count), flow_errors);
    check_value("upstream R beat count", 64'(exp_beats), 64'(us_count), flow_errors);
    $display("Errors: %0d downstream, %0d upstream, %0d protocol, %0d flow",
             ds_errors, us_errors, prop_errors, flow_errors);
    if (ds_errors + us_errors + prop_errors + flow_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
